/* hw/mem_pkg.sv */
package mem_pkg;

    // Bus widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;

    // Word index into the SRAM, address bits 9 to 2
    typedef logic [7:0]  word_idx_t;

    localparam int MEM_WORDS = 256;

    // Cycles from the rise of mem_req to the rise of mem_ack
    localparam int ACK_DELAY = 2;

    // Width of the SRAM ack delay counter
    localparam int ACK_CNT_W = $clog2(ACK_DELAY + 1);

    // Arbiter clients
    typedef enum logic {
        CLIENT_LSU   = 1'b0,
        CLIENT_FETCH = 1'b1
    } client_e;

endpackage

/* hw/lsu.sv */
`timescale 1ns/1ps

module lsu (
    input  logic            clk,
    input  logic            rst,

    // Core request side
    input  logic            cpu_valid,
    input  mem_pkg::addr_t  cpu_addr,
    input  mem_pkg::data_t  cpu_wdata,
    input  mem_pkg::strb_t  cpu_wstrb,
    output logic            cpu_ready,
    output mem_pkg::data_t  cpu_rdata,
    output logic            cpu_data_valid,

    // From writeback
    input  logic            store_commit,
    input  logic            flush,

    // Toward the arbiter
    output logic            lsu_valid,
    output mem_pkg::addr_t  lsu_addr,
    output mem_pkg::data_t  lsu_wdata,
    output mem_pkg::strb_t  lsu_wstrb,
    input  logic            lsu_ready,
    input  mem_pkg::data_t  lsu_rdata
);

    typedef enum logic [1:0] {
        IDLE,
        COMMIT_WAIT,
        STORE_SEND
    } lsu_state_e;

    lsu_state_e state;
    lsu_state_e next_state;

    logic load_pending;
    logic is_store;
    logic accept;
    logic accept_load;
    logic accept_store;

    // One-entry request buffer, shared by loads in flight and buffered stores
    mem_pkg::addr_t buf_addr;
    mem_pkg::data_t buf_wdata;
    mem_pkg::strb_t buf_wstrb;

    assign is_store     = cpu_wstrb != '0;
    assign cpu_ready    = (state == IDLE) && !load_pending;
    assign accept       = cpu_valid && cpu_ready;
    assign accept_load  = accept && !is_store;
    assign accept_store = accept && is_store;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (accept_store) begin
                    next_state = COMMIT_WAIT;
                end
            end
            COMMIT_WAIT: begin
                // Flush wins over a commit in the same cycle
                if (flush) begin
                    next_state = IDLE;
                end else if (store_commit) begin
                    next_state = STORE_SEND;
                end
            end
            STORE_SEND: begin
                if (lsu_ready) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    // Load in flight until the arbiter answers
    always_ff @(posedge clk) begin
        if (rst) begin
            load_pending <= 1'b0;
        end else if (accept_load && !lsu_ready) begin
            load_pending <= 1'b1;
        end else if (lsu_ready) begin
            load_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_addr  <= cpu_addr;
            buf_wdata <= cpu_wdata;
            buf_wstrb <= cpu_wstrb;
        end
    end

    // Loads pass straight through in the accept cycle, then come from the buffer
    assign lsu_valid = accept_load || load_pending || (state == STORE_SEND);
    assign lsu_addr  = cpu_ready ? cpu_addr  : buf_addr;
    assign lsu_wdata = cpu_ready ? cpu_wdata : buf_wdata;
    assign lsu_wstrb = cpu_ready ? cpu_wstrb : buf_wstrb;

    // Load data or store completion
    assign cpu_rdata      = lsu_rdata;
    assign cpu_data_valid = lsu_ready;

endmodule

/* hw/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic            clk,
    input  logic            rst,

    // Redirect from the core
    input  logic            redirect,
    input  mem_pkg::addr_t  redirect_pc,

    // Instruction output
    output mem_pkg::data_t  instr,
    output logic            instr_valid,
    output mem_pkg::addr_t  instr_pc,
    input  logic            instr_ready,

    // Toward the arbiter
    output logic            fetch_valid,
    output mem_pkg::addr_t  fetch_addr,
    input  logic            fetch_ready,
    input  mem_pkg::data_t  fetch_rdata
);

    mem_pkg::addr_t pc;
    mem_pkg::addr_t req_addr;
    logic           req_valid;
    logic           drop;

    logic           buf_valid;
    mem_pkg::data_t buf_data;
    mem_pkg::addr_t buf_pc;

    logic take_reply;
    logic issue;

    // A reply is dropped if a redirect came while it was in flight
    assign take_reply = fetch_ready && !drop && !redirect;
    // No prefetch: next request only once the buffer is empty
    assign issue      = !req_valid && !buf_valid && !redirect;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= '0;
            req_valid <= 1'b0;
            drop      <= 1'b0;
            buf_valid <= 1'b0;
        end else if (redirect) begin
            pc        <= redirect_pc;
            buf_valid <= 1'b0;
            req_valid <= req_valid && !fetch_ready;
            drop      <= req_valid && !fetch_ready;
        end else begin
            if (fetch_ready) begin
                req_valid <= 1'b0;
                drop      <= 1'b0;
            end else if (issue) begin
                req_valid <= 1'b1;
            end
            if (take_reply) begin
                buf_valid <= 1'b1;
                pc        <= req_addr + 32'd4;
            end else if (instr_valid && instr_ready) begin
                buf_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req_addr <= pc;
        end
        if (take_reply) begin
            buf_data <= fetch_rdata;
            buf_pc   <= req_addr;
        end
    end

    assign fetch_valid = req_valid;
    assign fetch_addr  = req_addr;

    assign instr       = buf_data;
    assign instr_pc    = buf_pc;
    assign instr_valid = buf_valid;

endmodule

/* hw/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
    input  logic               clk,
    input  logic               rst,

    // LSU client
    input  logic               lsu_valid,
    input  mem_pkg::addr_t     lsu_addr,
    input  mem_pkg::data_t     lsu_wdata,
    input  mem_pkg::strb_t     lsu_wstrb,
    output logic               lsu_ready,
    output mem_pkg::data_t     lsu_rdata,

    // Fetch client, read only
    input  logic               fetch_valid,
    input  mem_pkg::addr_t     fetch_addr,
    output logic               fetch_ready,
    output mem_pkg::data_t     fetch_rdata,

    // Four-phase side toward the SRAM
    output logic               mem_req,
    output mem_pkg::word_idx_t mem_idx,
    output mem_pkg::data_t     mem_wdata,
    output mem_pkg::strb_t     mem_wstrb,
    input  logic               mem_ack,
    input  mem_pkg::data_t     mem_rdata
);

    typedef enum logic [1:0] {
        IDLE,
        REQ_HIGH,
        REQ_LOW
    } arb_state_e;

    arb_state_e       state;
    mem_pkg::client_e grant;
    mem_pkg::client_e last;
    mem_pkg::client_e pick;
    logic             any_valid;
    logic             done;

    assign any_valid = lsu_valid || fetch_valid;
    assign done      = (state == REQ_HIGH) && mem_ack;

    // Round robin, the client not served last wins a tie
    always_comb begin
        if (fetch_valid && (!lsu_valid || last == mem_pkg::CLIENT_LSU)) begin
            pick = mem_pkg::CLIENT_FETCH;
        end else begin
            pick = mem_pkg::CLIENT_LSU;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            grant <= mem_pkg::CLIENT_LSU;
            last  <= mem_pkg::CLIENT_FETCH;
        end else begin
            case (state)
                IDLE: begin
                    if (any_valid) begin
                        grant <= pick;
                        state <= REQ_HIGH;
                    end
                end
                REQ_HIGH: begin
                    if (mem_ack) begin
                        last  <= grant;
                        state <= REQ_LOW;
                    end
                end
                REQ_LOW: begin
                    if (!mem_ack) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Request fields latched at grant
    always_ff @(posedge clk) begin
        if (state == IDLE && any_valid) begin
            if (pick == mem_pkg::CLIENT_FETCH) begin
                mem_idx   <= fetch_addr[2 +: $bits(mem_pkg::word_idx_t)];
                mem_wdata <= '0;
                mem_wstrb <= '0;
            end else begin
                mem_idx   <= lsu_addr[2 +: $bits(mem_pkg::word_idx_t)];
                mem_wdata <= lsu_wdata;
                mem_wstrb <= lsu_wstrb;
            end
        end
    end

    assign mem_req = (state == REQ_HIGH);

    // One-cycle ready pulse when the ack is first seen
    assign lsu_ready   = done && (grant == mem_pkg::CLIENT_LSU);
    assign fetch_ready = done && (grant == mem_pkg::CLIENT_FETCH);
    assign lsu_rdata   = mem_rdata;
    assign fetch_rdata = mem_rdata;

endmodule

/* hw/sram_bank.sv */
`timescale 1ns/1ps

module sram_bank (
    input  logic               clk,
    input  logic               rst,

    input  logic               mem_req,
    input  mem_pkg::word_idx_t mem_idx,
    input  mem_pkg::data_t     mem_wdata,
    input  mem_pkg::strb_t     mem_wstrb,
    output logic               mem_ack,
    output mem_pkg::data_t     mem_rdata
);

    mem_pkg::data_t mem [mem_pkg::MEM_WORDS];

    logic [mem_pkg::ACK_CNT_W-1:0] cnt;
    logic                          fire;

    initial begin
        for (int i = 0; i < mem_pkg::MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // Last wait cycle before the ack rises
    assign fire = mem_req && !mem_ack
               && (cnt == mem_pkg::ACK_CNT_W'(mem_pkg::ACK_DELAY - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt     <= '0;
            mem_ack <= 1'b0;
        end else if (!mem_req) begin
            cnt     <= '0;
            mem_ack <= 1'b0;
        end else if (fire) begin
            cnt     <= '0;
            mem_ack <= 1'b1;
        end else if (!mem_ack) begin
            cnt <= cnt + 1'b1;
        end
    end

    // Access happens together with the rise of the ack
    always_ff @(posedge clk) begin
        if (fire) begin
            mem_rdata <= mem[mem_idx];
            for (int b = 0; b < $bits(mem_pkg::strb_t); b++) begin
                if (mem_wstrb[b]) begin
                    mem[mem_idx][8*b +: 8] <= mem_wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

/* hw/mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic            clk,
    input  logic            rst,

    // Data side
    input  logic            cpu_valid,
    input  mem_pkg::addr_t  cpu_addr,
    input  mem_pkg::data_t  cpu_wdata,
    input  mem_pkg::strb_t  cpu_wstrb,
    output logic            cpu_ready,
    output mem_pkg::data_t  cpu_rdata,
    output logic            cpu_data_valid,
    input  logic            store_commit,
    input  logic            flush,

    // Instruction side
    input  logic            redirect,
    input  mem_pkg::addr_t  redirect_pc,
    output mem_pkg::data_t  instr,
    output logic            instr_valid,
    output mem_pkg::addr_t  instr_pc,
    input  logic            instr_ready
);

    logic               lsu_valid;
    mem_pkg::addr_t     lsu_addr;
    mem_pkg::data_t     lsu_wdata;
    mem_pkg::strb_t     lsu_wstrb;
    logic               lsu_ready;
    mem_pkg::data_t     lsu_rdata;

    logic               fetch_valid;
    mem_pkg::addr_t     fetch_addr;
    logic               fetch_ready;
    mem_pkg::data_t     fetch_rdata;

    logic               mem_req;
    mem_pkg::word_idx_t mem_idx;
    mem_pkg::data_t     mem_wdata;
    mem_pkg::strb_t     mem_wstrb;
    logic               mem_ack;
    mem_pkg::data_t     mem_rdata;

    lsu u_lsu (
        .clk            (clk),
        .rst            (rst),
        .cpu_valid      (cpu_valid),
        .cpu_addr       (cpu_addr),
        .cpu_wdata      (cpu_wdata),
        .cpu_wstrb      (cpu_wstrb),
        .cpu_ready      (cpu_ready),
        .cpu_rdata      (cpu_rdata),
        .cpu_data_valid (cpu_data_valid),
        .store_commit   (store_commit),
        .flush          (flush),
        .lsu_valid      (lsu_valid),
        .lsu_addr       (lsu_addr),
        .lsu_wdata      (lsu_wdata),
        .lsu_wstrb      (lsu_wstrb),
        .lsu_ready      (lsu_ready),
        .lsu_rdata      (lsu_rdata)
    );

    fetch_unit u_fetch (
        .clk         (clk),
        .rst         (rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_pc    (instr_pc),
        .instr_ready (instr_ready),
        .fetch_valid (fetch_valid),
        .fetch_addr  (fetch_addr),
        .fetch_ready (fetch_ready),
        .fetch_rdata (fetch_rdata)
    );

    mem_arbiter u_arb (
        .clk         (clk),
        .rst         (rst),
        .lsu_valid   (lsu_valid),
        .lsu_addr    (lsu_addr),
        .lsu_wdata   (lsu_wdata),
        .lsu_wstrb   (lsu_wstrb),
        .lsu_ready   (lsu_ready),
        .lsu_rdata   (lsu_rdata),
        .fetch_valid (fetch_valid),
        .fetch_addr  (fetch_addr),
        .fetch_ready (fetch_ready),
        .fetch_rdata (fetch_rdata),
        .mem_req     (mem_req),
        .mem_idx     (mem_idx),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata)
    );

    sram_bank u_sram (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_idx   (mem_idx),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

endmodule

/* test/mem_asserts.sv */
`timescale 1ns/1ps

module mem_asserts (
    input  logic           clk,
    input  logic           rst,
    input  logic           mem_req,
    input  logic           mem_ack,
    input  mem_pkg::strb_t mem_wstrb,
    input  logic           lsu_valid,
    input  logic           lsu_ready,
    input  logic           fetch_valid,
    input  logic           fetch_ready,
    input  logic           commit_wait
);

    int failures = 0;

    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_ack |=> mem_req)
        else begin
            failures++;
            $error("mem_req fell before mem_ack");
        end

    a_req_after_ack: assert property (@(posedge clk) disable iff (rst)
        $rose(mem_req) |-> !mem_ack)
        else begin
            failures++;
            $error("mem_req rose while mem_ack was still high");
        end

    a_lsu_hold: assert property (@(posedge clk) disable iff (rst)
        lsu_valid && !lsu_ready |=> lsu_valid)
        else begin
            failures++;
            $error("lsu_valid dropped before lsu_ready");
        end

    a_fetch_hold: assert property (@(posedge clk) disable iff (rst)
        fetch_valid && !fetch_ready |=> fetch_valid)
        else begin
            failures++;
            $error("fetch_valid dropped before fetch_ready");
        end

    // Uncommitted store must never reach the SRAM
    a_no_early_write: assert property (@(posedge clk) disable iff (rst)
        mem_req && (mem_wstrb != '0) |-> !commit_wait)
        else begin
            failures++;
            $error("memory write while the LSU waits for commit");
        end

endmodule

// COMMIT_WAIT is the second value of the LSU state enum
bind mem_subsys_top mem_asserts u_asserts (
    .clk         (clk),
    .rst         (rst),
    .mem_req     (mem_req),
    .mem_ack     (mem_ack),
    .mem_wstrb   (mem_wstrb),
    .lsu_valid   (lsu_valid),
    .lsu_ready   (lsu_ready),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready),
    .commit_wait (u_lsu.state == 2'd1)
);

/* test/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

    localparam int ITERS = 40;
    localparam int BURST = 24;
    localparam int OPS = 2 * ITERS + BURST + ITERS / 8;
    localparam int WATCHDOG_CYCLES = OPS * 4 * (mem_pkg::ACK_DELAY + 4) + 500;

    logic           clk;
    logic           rst;
    logic           cpu_valid;
    mem_pkg::addr_t cpu_addr;
    mem_pkg::data_t cpu_wdata;
    mem_pkg::strb_t cpu_wstrb;
    logic           cpu_ready;
    mem_pkg::data_t cpu_rdata;
    logic           cpu_data_valid;
    logic           store_commit;
    logic           flush;
    logic           redirect;
    mem_pkg::addr_t redirect_pc;
    mem_pkg::data_t instr;
    logic           instr_valid;
    mem_pkg::addr_t instr_pc;
    logic           instr_ready;

    // Reference copy of the SRAM contents
    mem_pkg::data_t shadow [mem_pkg::MEM_WORDS];

    logic [31:0]    rng;
    logic [31:0]    ready_rng;
    int             mismatches;
    int             other_errs;
    mem_pkg::addr_t exp_pc;
    mem_pkg::data_t exp_word;
    logic           captured;
    logic           last_fetch;
    logic           have_last;
    logic           other_waited;
    int             lsu_grants;
    int             fetch_grants;

    mem_subsys_top dut (
        .clk            (clk),
        .rst            (rst),
        .cpu_valid      (cpu_valid),
        .cpu_addr       (cpu_addr),
        .cpu_wdata      (cpu_wdata),
        .cpu_wstrb      (cpu_wstrb),
        .cpu_ready      (cpu_ready),
        .cpu_rdata      (cpu_rdata),
        .cpu_data_valid (cpu_data_valid),
        .store_commit   (store_commit),
        .flush          (flush),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .instr          (instr),
        .instr_valid    (instr_valid),
        .instr_pc       (instr_pc),
        .instr_ready    (instr_ready)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] got_v);
        mismatches++;
        $display("MISMATCH t=%0t %s expected=%h got=%h", $time, name, exp_v, got_v);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

    // Random stalls on the instruction output
    initial begin
        ready_rng = 32'h20bf8b05;
        forever begin
            @(posedge clk);
            #1;
            ready_rng = xorshift(ready_rng);
            instr_ready = ready_rng[1:0] != 2'b00;
        end
    end

    task automatic check_fetch();
        if (redirect) begin
            exp_pc   = redirect_pc;
            captured = 1'b0;
        end else if (instr_valid) begin
            // Word read from memory just before the buffer filled
            if (!captured) begin
                exp_word = shadow[exp_pc[9:2]];
                captured = 1'b1;
            end
            assert (instr_pc == exp_pc) else report_mismatch("instr_pc", exp_pc, instr_pc);
            assert (instr == exp_word) else report_mismatch("instr", exp_word, instr);
            if (instr_ready) begin
                captured = 1'b0;
                exp_pc   = exp_pc + 32'd4;
            end
        end
    endtask

    task automatic check_fairness();
        logic served_fetch;
        if (dut.lsu_ready || dut.fetch_ready) begin
            served_fetch = dut.fetch_ready;
            assert (!(have_last && served_fetch == last_fetch && other_waited)) else begin
                other_errs++;
                $display("Arbiter served one client twice while the other waited at %0t",
                         $time);
            end
            other_waited = served_fetch ? dut.lsu_valid : dut.fetch_valid;
            last_fetch   = served_fetch;
            have_last    = 1'b1;
            if (served_fetch) begin
                fetch_grants++;
            end else begin
                lsu_grants++;
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            check_fetch();
            check_fairness();
        end
    end

    task automatic do_load(input mem_pkg::addr_t a);
        mem_pkg::data_t got;
        cpu_valid = 1'b1;
        cpu_addr  = a;
        cpu_wdata = '0;
        cpu_wstrb = '0;
        @(negedge clk);
        while (!cpu_ready) @(negedge clk);
        @(posedge clk);
        #1;
        cpu_valid = 1'b0;
        @(negedge clk);
        while (!cpu_data_valid) @(negedge clk);
        got = cpu_rdata;
        assert (got == shadow[a[9:2]]) else report_mismatch("cpu_rdata", shadow[a[9:2]], got);
        @(posedge clk);
        #1;
    endtask

    task automatic do_store(input mem_pkg::addr_t a, input mem_pkg::data_t d,
                            input mem_pkg::strb_t s, input logic commit);
        int pulses;
        pulses    = 0;
        cpu_valid = 1'b1;
        cpu_addr  = a;
        cpu_wdata = d;
        cpu_wstrb = s;
        @(negedge clk);
        while (!cpu_ready) @(negedge clk);
        @(posedge clk);
        #1;
        cpu_valid    = 1'b0;
        cpu_wstrb    = '0;
        store_commit = commit;
        flush        = !commit;
        @(posedge clk);
        #1;
        store_commit = 1'b0;
        flush        = 1'b0;
        if (commit) begin
            @(negedge clk);
            while (!cpu_data_valid) @(negedge clk);
            for (int b = 0; b < 4; b++) begin
                if (s[b]) begin
                    shadow[a[9:2]][8*b +: 8] = d[8*b +: 8];
                end
            end
        end else begin
            repeat (2 * (mem_pkg::ACK_DELAY + 4)) begin
                @(negedge clk);
                if (cpu_data_valid) begin
                    pulses++;
                end
            end
            assert (pulses == 0) else begin
                other_errs++;
                $display("cpu_data_valid pulsed after a flushed store at %0t", $time);
            end
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        mem_pkg::addr_t a;
        mem_pkg::data_t d;
        mem_pkg::strb_t s;
        logic           commit;
        rst = 1'b1;
        cpu_valid = 1'b0;
        cpu_addr = '0;
        cpu_wdata = '0;
        cpu_wstrb = '0;
        store_commit = 1'b0;
        flush = 1'b0;
        redirect = 1'b0;
        redirect_pc = '0;
        instr_ready = 1'b0;
        rng = 32'h20bf8b05;
        mismatches = 0;
        other_errs = 0;
        exp_pc = '0;
        exp_word = '0;
        captured = 1'b0;
        have_last = 1'b0;
        last_fetch = 1'b0;
        other_waited = 1'b0;
        lsu_grants = 0;
        fetch_grants = 0;
        for (int i = 0; i < mem_pkg::MEM_WORDS; i++) begin
            shadow[i] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // Stores with commit or flush and a load of the same word after each
        for (int i = 0; i < ITERS; i++) begin
            rng = xorshift(rng);
            a = mem_pkg::addr_t'(rng[4:0]) << 2;
            s = (i % 2 == 0) ? 4'hf : rng[11:8];
            if (s == '0) begin
                s = 4'h6;
            end
            commit = rng[15:13] != 3'b000;
            rng = xorshift(rng);
            d = rng;
            do_store(a, d, s, commit);
            do_load(a);
            if (i % 8 == 7) begin
                rng = xorshift(rng);
                redirect_pc = mem_pkg::addr_t'(rng[7:0]) << 2;
                redirect = 1'b1;
                @(posedge clk);
                #1;
                redirect = 1'b0;
            end
        end

        // Grant counts cover only the back to back phase
        lsu_grants   = 0;
        fetch_grants = 0;

        // Back to back loads racing the fetch unit
        for (int i = 0; i < BURST; i++) begin
            rng = xorshift(rng);
            do_load(mem_pkg::addr_t'(rng[4:0]) << 2);
        end
        repeat (20) @(posedge clk);

        assert (lsu_grants > 0 && fetch_grants > 0) else begin
            other_errs++;
            $display("A client never completed during back to back loads: lsu=%0d fetch=%0d",
                     lsu_grants, fetch_grants);
        end

        $display("Errors: mismatches=%0d other=%0d assertions=%0d",
                 mismatches, other_errs, dut.u_asserts.failures);
        if (mismatches + other_errs + dut.u_asserts.failures == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* project.f */
hw/mem_pkg.sv
hw/lsu.sv
hw/fetch_unit.sv
hw/mem_arbiter.sv
hw/sram_bank.sv
hw/mem_subsys_top.sv
test/mem_asserts.sv
test/tb_top.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_top -f project.f -o Vtb_top
	./obj_dir/Vtb_top > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Something failed" sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log
